/* icache_pkg.sv */
package icache_pkg;

    // cache geometry
    localparam int num_ways       = 4;
    localparam int num_sets       = 128;
    localparam int words_per_line = 8;
    localparam int sweep_last     = num_sets - 1;

    // id used on ar, expected back on r
    localparam logic [3:0] icache_axi_id = 4'd4;

    // address fields: tag 31..12, index 11..5, half 4
    typedef logic [19:0]         tag_t;
    typedef logic [6:0]          index_t;

    typedef logic [31:0]         word_t;
    typedef logic [127:0]        half_t;
    typedef logic [255:0]        line_t;

    typedef logic [num_ways-1:0] way_mask_t;

    // tree bits: [2] root, [1] ways 0/1, [0] ways 2/3
    typedef logic [2:0]          plru_t;

    typedef enum logic [2:0] {
        reset_sweep,
        idle,
        run,
        miss,
        refill,
        finish,
        recover
    } cache_state_t;

endpackage

/* icache_way.sv */
`timescale 1ns/1ns

module icache_way import icache_pkg::*; (
    input  logic   clk,
    input  index_t index,
    input  logic   tag_we,
    input  tag_t   wtag,
    input  logic   wvalid,
    input  logic   data_we,
    input  line_t  wline,
    output tag_t   rtag,
    output logic   rvalid,
    output line_t  rline
);

    tag_t  tag_mem   [num_sets];
    logic  valid_mem [num_sets];
    line_t line_mem  [num_sets];

    // tag and valid written together
    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[index]   <= wtag;
            valid_mem[index] <= wvalid;
        end
        if (data_we) begin
            line_mem[index] <= wline;
        end
    end

    // registered read, returns old contents on a same-cycle write
    always_ff @(posedge clk) begin
        rtag   <= tag_mem[index];
        rvalid <= valid_mem[index];
        rline  <= line_mem[index];
    end

endmodule

/* icache_ctrl.sv */
`timescale 1ns/1ns

module icache_ctrl import icache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        req,
    input  logic [31:0] addr,
    output logic        index_ok,
    output logic        data_ok,
    input  logic        hit,
    input  logic        early_hit,
    input  logic        burst_done,
    input  way_mask_t   victim,
    output logic        choose_victim,
    output logic        update_plru,
    output logic        advance,
    output logic        reload,
    output logic        in_miss,
    output logic        in_refill,
    output logic        in_finish,
    output tag_t        req_tag,
    output index_t      req_index,
    output logic        req_half,
    output index_t      array_index,
    output way_mask_t   tag_we,
    output way_mask_t   data_we,
    output logic        wvalid,
    output logic        miss_start
);

    cache_state_t state;
    index_t       sweep_cnt;

    // read stage
    logic   rd_valid;
    tag_t   rd_tag;
    index_t rd_index;
    logic   rd_half;

    // compare stage, payload lives in req_*
    logic   cmp_valid;

    logic   run_miss;
    logic   accept;

    ////////////////////////////////////////////////////////////
    // cpu handshake

    assign run_miss = (state == run) && cmp_valid && !hit;
    assign data_ok  = cmp_valid && (((state == run) && hit) || early_hit);
    assign index_ok = (state == run) && (!cmp_valid || data_ok);
    assign accept   = req && index_ok;

    assign advance  = index_ok;
    assign reload   = (state == idle);

    assign choose_victim = run_miss;
    assign miss_start    = run_miss;
    assign update_plru   = (state == miss);
    assign in_miss       = (state == miss);
    assign in_refill     = (state == refill);
    assign in_finish     = (state == finish);

    ////////////////////////////////////////////////////////////
    // state machine

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= reset_sweep;
        end else begin
            case (state)
                reset_sweep: begin
                    if (sweep_cnt == index_t'(sweep_last)) begin
                        state <= idle;
                    end
                end
                idle:    state <= run;
                run: begin
                    if (run_miss) begin
                        state <= miss;
                    end
                end
                // ar handshake itself is tracked in the refill unit
                miss:    state <= refill;
                refill: begin
                    if (burst_done) begin
                        state <= finish;
                    end
                end
                finish:  state <= recover;
                recover: state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // one set cleared per cycle
    always_ff @(posedge clk) begin
        if (!rst) begin
            sweep_cnt <= '0;
        end else if (state == reset_sweep) begin
            sweep_cnt <= sweep_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // pipeline registers

    always_ff @(posedge clk) begin
        if (!rst) begin
            rd_valid <= 1'b0;
        end else if (advance) begin
            rd_valid <= accept;
        end else if (reload) begin
            rd_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rd_tag   <= addr[31:12];
            rd_index <= addr[11:5];
            rd_half  <= addr[4];
        end
    end

    // idle moves the stalled entry on together with its re-read
    always_ff @(posedge clk) begin
        if (!rst) begin
            cmp_valid <= 1'b0;
        end else if (advance || reload) begin
            cmp_valid <= rd_valid;
        end else if (data_ok) begin
            cmp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (advance || reload) begin
            req_tag   <= rd_tag;
            req_index <= rd_index;
            req_half  <= rd_half;
        end
    end

    ////////////////////////////////////////////////////////////
    // array port

    // recover already reads the stalled set so idle can capture it
    always_comb begin
        case (state)
            reset_sweep:   array_index = sweep_cnt;
            finish:        array_index = req_index;
            recover, idle: array_index = rd_index;
            run:           array_index = addr[11:5];
            default:       array_index = req_index;
        endcase
    end

    assign tag_we  = (state == reset_sweep) ? '1 :
                     (state == finish)      ? victim : '0;
    assign data_we = (state == finish) ? victim : '0;
    assign wvalid  = (state != reset_sweep);

endmodule

/* icache_hit_select.sv */
`timescale 1ns/1ns

module icache_hit_select import icache_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                advance,
    input  logic                reload,
    input  tag_t                req_tag,
    input  logic                req_half,
    input  tag_t                way_tag   [num_ways],
    input  logic [num_ways-1:0] way_valid,
    input  line_t               way_line  [num_ways],
    input  logic                early_hit,
    input  half_t               early_half,
    output logic                hit,
    output half_t               rdata
);

    tag_t       cmp_tag  [num_ways];
    way_mask_t  cmp_valid;
    line_t      cmp_line [num_ways];
    way_mask_t  hit_way;
    logic [1:0] hit_idx;
    line_t      hit_line;

    always_ff @(posedge clk) begin
        if (!rst) begin
            cmp_valid <= '0;
        end else if (advance || reload) begin
            cmp_valid <= way_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance || reload) begin
            cmp_tag  <= way_tag;
            cmp_line <= way_line;
        end
    end

    // parallel compare, at most one way matches
    always_comb begin
        hit_idx = '0;
        for (int w = 0; w < num_ways; w++) begin
            hit_way[w] = cmp_valid[w] && (cmp_tag[w] == req_tag);
            if (hit_way[w]) begin
                hit_idx = 2'(w);
            end
        end
    end

    assign hit      = |hit_way;
    assign hit_line = cmp_line[hit_idx];

    // fill buffer wins while the line is still arriving
    assign rdata = early_hit ? early_half        :
                   req_half  ? hit_line[255:128] : hit_line[127:0];

endmodule

/* icache_plru.sv */
`timescale 1ns/1ns

module icache_plru import icache_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  index_t    index,
    input  logic      choose,
    input  logic      update,
    output way_mask_t victim
);

    plru_t tree [num_sets];
    plru_t cur;

    assign cur = tree[index];

    // root picks the pair, lower bits pick the way
    always_ff @(posedge clk) begin
        if (!rst) begin
            victim <= '0;
        end else if (choose) begin
            if (!cur[2]) begin
                victim <= cur[1] ? 4'b0010 : 4'b0001;
            end else begin
                victim <= cur[0] ? 4'b1000 : 4'b0100;
            end
        end
    end

    // point the tree away from the way just filled
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int s = 0; s < num_sets; s++) begin
                tree[s] <= '0;
            end
        end else if (update) begin
            case (victim)
                4'b0001: tree[index] <= {1'b1, 1'b1, cur[0]};
                4'b0010: tree[index] <= {1'b1, 1'b0, cur[0]};
                4'b0100: tree[index] <= {1'b0, cur[1], 1'b1};
                4'b1000: tree[index] <= {1'b0, cur[1], 1'b0};
                default: tree[index] <= cur;
            endcase
        end
    end

endmodule

/* icache_refill.sv */
`timescale 1ns/1ns

module icache_refill import icache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        miss_start,
    input  logic        in_miss,
    input  logic        in_refill,
    input  logic        in_finish,
    input  tag_t        req_tag,
    input  index_t      req_index,
    input  logic        req_half,
    output logic [31:0] araddr,
    output logic        arvalid,
    input  logic        arready,
    input  logic [3:0]  rid,
    input  word_t       rdata_axi,
    input  logic        rlast,
    input  logic        rvalid,
    output logic        rready,
    output line_t       fill_line,
    output logic        early_hit,
    output half_t       early_half,
    output logic        burst_done
);

    tag_t                      fill_tag;
    index_t                    fill_index;
    logic                      fill_half;
    logic                      ar_done;
    logic [2:0]                beat_cnt;
    word_t                     fill_buf [words_per_line];
    logic [words_per_line-1:0] fill_valid;
    logic                      beat;
    logic                      half_ready;

    ////////////////////////////////////////////////////////////
    // address channel

    always_ff @(posedge clk) begin
        if (miss_start) begin
            fill_tag   <= req_tag;
            fill_index <= req_index;
            fill_half  <= req_half;
        end
    end

    // wrap burst starts at the requested half
    assign araddr  = {fill_tag, fill_index, fill_half, 4'b0000};
    assign arvalid = (in_miss || in_refill) && !ar_done;

    always_ff @(posedge clk) begin
        if (!rst) begin
            ar_done <= 1'b0;
        end else if (miss_start) begin
            ar_done <= 1'b0;
        end else if (arvalid && arready) begin
            ar_done <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // read data channel

    assign rready     = in_refill;
    assign beat       = rvalid && rready && (rid == icache_axi_id);
    assign burst_done = beat && rlast;

    // 3-bit counter wraps the same way the bus does
    always_ff @(posedge clk) begin
        if (!rst) begin
            beat_cnt <= '0;
        end else if (miss_start) begin
            beat_cnt <= {req_half, 2'b00};
        end else if (beat) begin
            beat_cnt <= beat_cnt + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (beat) begin
            fill_buf[beat_cnt] <= rdata_axi;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            fill_valid <= '0;
        end else if (in_finish) begin
            fill_valid <= '0;
        end else if (beat) begin
            fill_valid[beat_cnt] <= 1'b1;
        end
    end

    assign fill_line = {fill_buf[7], fill_buf[6], fill_buf[5], fill_buf[4],
                        fill_buf[3], fill_buf[2], fill_buf[1], fill_buf[0]};

    ////////////////////////////////////////////////////////////
    // early delivery

    assign half_ready = fill_half ? &fill_valid[7:4] : &fill_valid[3:0];

    assign early_hit  = half_ready && (fill_tag == req_tag) &&
                        (fill_index == req_index) && (fill_half == req_half);

    assign early_half = fill_half ?
                        {fill_buf[7], fill_buf[6], fill_buf[5], fill_buf[4]} :
                        {fill_buf[3], fill_buf[2], fill_buf[1], fill_buf[0]};

endmodule

/* icache_top.sv */
`timescale 1ns/1ns

module icache_top import icache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        req,
    input  logic [31:0] addr,
    output logic        index_ok,
    output logic        data_ok,
    output half_t       rdata,
    output logic [31:0] araddr,
    output logic        arvalid,
    input  logic        arready,
    input  logic [3:0]  rid,
    input  word_t       rdata_axi,
    input  logic        rlast,
    input  logic        rvalid,
    output logic        rready
);

    logic      hit;
    logic      early_hit;
    half_t     early_half;
    logic      burst_done;
    way_mask_t victim;
    logic      choose_victim;
    logic      update_plru;
    logic      advance;
    logic      reload;
    logic      in_miss;
    logic      in_refill;
    logic      in_finish;
    logic      miss_start;

    tag_t      req_tag;
    index_t    req_index;
    logic      req_half;

    index_t    array_index;
    way_mask_t tag_we;
    way_mask_t data_we;
    logic      wvalid;
    line_t     fill_line;

    tag_t                way_tag  [num_ways];
    logic [num_ways-1:0] way_valid;
    line_t               way_line [num_ways];

    ////////////////////////////////////////////////////////////
    // control and side blocks

    icache_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .addr          (addr),
        .index_ok      (index_ok),
        .data_ok       (data_ok),
        .hit           (hit),
        .early_hit     (early_hit),
        .burst_done    (burst_done),
        .victim        (victim),
        .choose_victim (choose_victim),
        .update_plru   (update_plru),
        .advance       (advance),
        .reload        (reload),
        .in_miss       (in_miss),
        .in_refill     (in_refill),
        .in_finish     (in_finish),
        .req_tag       (req_tag),
        .req_index     (req_index),
        .req_half      (req_half),
        .array_index   (array_index),
        .tag_we        (tag_we),
        .data_we       (data_we),
        .wvalid        (wvalid),
        .miss_start    (miss_start)
    );

    icache_plru u_plru (
        .clk    (clk),
        .rst    (rst),
        .index  (req_index),
        .choose (choose_victim),
        .update (update_plru),
        .victim (victim)
    );

    icache_refill u_refill (
        .clk        (clk),
        .rst        (rst),
        .miss_start (miss_start),
        .in_miss    (in_miss),
        .in_refill  (in_refill),
        .in_finish  (in_finish),
        .req_tag    (req_tag),
        .req_index  (req_index),
        .req_half   (req_half),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rid        (rid),
        .rdata_axi  (rdata_axi),
        .rlast      (rlast),
        .rvalid     (rvalid),
        .rready     (rready),
        .fill_line  (fill_line),
        .early_hit  (early_hit),
        .early_half (early_half),
        .burst_done (burst_done)
    );

    ////////////////////////////////////////////////////////////
    // storage and compare

    // fill tag is the compare-stage tag held through finish
    generate
        for (genvar w = 0; w < num_ways; w++) begin : g_way
            icache_way u_way (
                .clk     (clk),
                .index   (array_index),
                .tag_we  (tag_we[w]),
                .wtag    (req_tag),
                .wvalid  (wvalid),
                .data_we (data_we[w]),
                .wline   (fill_line),
                .rtag    (way_tag[w]),
                .rvalid  (way_valid[w]),
                .rline   (way_line[w])
            );
        end
    endgenerate

    icache_hit_select u_hit_select (
        .clk        (clk),
        .rst        (rst),
        .advance    (advance),
        .reload     (reload),
        .req_tag    (req_tag),
        .req_half   (req_half),
        .way_tag    (way_tag),
        .way_valid  (way_valid),
        .way_line   (way_line),
        .early_hit  (early_hit),
        .early_half (early_half),
        .hit        (hit),
        .rdata      (rdata)
    );

endmodule

/* icache_assertions.sv */
`timescale 1ns/1ns

module icache_assertions import icache_pkg::*; (
    input logic clk,
    input logic rst,
    input logic req,
    input logic index_ok,
    input logic data_ok,
    input logic arvalid,
    input logic arready
);

    int         failures = 0;
    logic [7:0] sweep_cycles;
    logic [3:0] outstanding;

    // cycles since reset release, saturates after the sweep
    always_ff @(posedge clk) begin
        if (!rst) begin
            sweep_cycles <= '0;
        end else if (sweep_cycles != 8'(num_sets)) begin
            sweep_cycles <= sweep_cycles + 8'd1;
        end
    end

    // accepted fetches still waiting for data_ok
    always_ff @(posedge clk) begin
        if (!rst) begin
            outstanding <= '0;
        end else if (req && index_ok && !data_ok) begin
            outstanding <= outstanding + 4'd1;
        end else if (!(req && index_ok) && data_ok) begin
            outstanding <= outstanding - 4'd1;
        end
    end

    arvalid_held: assert property (@(posedge clk) disable iff (!rst)
        arvalid && !arready |=> arvalid)
        else begin
            $error("arvalid dropped before arready");
            failures++;
        end

    data_ok_tracked: assert property (@(posedge clk) disable iff (!rst)
        data_ok |-> outstanding != 4'd0)
        else begin
            $error("data_ok with no accepted fetch outstanding");
            failures++;
        end

    sweep_quiet: assert property (@(posedge clk) disable iff (!rst)
        sweep_cycles < 8'(num_sets) |-> !index_ok)
        else begin
            $error("index_ok high during the invalidation sweep");
            failures++;
        end

endmodule

bind icache_top icache_assertions assertions_i (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .index_ok (index_ok),
    .data_ok  (data_ok),
    .arvalid  (arvalid),
    .arready  (arready)
);

/* tb_icache.sv */
`timescale 1ns/1ns

module tb_icache import icache_pkg::*; ();

    localparam int          clk_period      = 20;
    localparam int          max_tests       = 64;
    localparam int          cycles_per_test = 300;
    localparam logic [31:0] mem_offset      = 32'h1000_0000;
    localparam logic [31:0] lcg_seed        = 32'd52841;

    logic        clk       = 1'b0;
    logic        rst       = 1'b0;
    logic        req       = 1'b0;
    logic [31:0] addr      = '0;
    logic        index_ok;
    logic        data_ok;
    half_t       rdata;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready   = 1'b0;
    logic [3:0]  rid       = icache_axi_id;
    word_t       rdata_axi = '0;
    logic        rlast     = 1'b0;
    logic        rvalid    = 1'b0;
    logic        rready;

    // address, flags and half per file line
    logic [127:0] vec_mem    [3*max_tests];
    logic [31:0]  test_addr  [max_tests];
    logic [1:0]   test_flags [max_tests];
    half_t        test_half  [max_tests];
    int           n_tests     = 0;
    logic         file_loaded = 1'b0;

    int           mismatch_count = 0;
    int           other_count    = 0;
    int           results_done   = 0;
    int           accepted       = 0;
    int           cycle_cnt      = 0;
    logic         seen_index_ok  = 1'b0;
    int           pending_q [$];
    int           accept_cycle [max_tests];
    int           ar_seen      [max_tests];

    logic [31:0]  rand_state   = lcg_seed;
    logic         burst_active = 1'b0;
    logic [31:0]  burst_addr   = '0;
    int           beats_done   = 0;

    icache_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .addr      (addr),
        .index_ok  (index_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rid       (rid),
        .rdata_axi (rdata_axi),
        .rlast     (rlast),
        .rvalid    (rvalid),
        .rready    (rready)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    // each word is its word address plus a fixed offset
    function automatic word_t beat_word(logic [31:0] base, int beat);
        logic [2:0]  offset;
        logic [31:0] word_addr;
        offset    = base[4:2] + beat[2:0];
        word_addr = {2'b00, base[31:5], offset};
        return word_addr + mem_offset;
    endfunction

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
            mismatch_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // axi read slave with random delays

    always @(posedge clk) begin
        int          beats_next;
        logic [31:0] rnd;
        if (!rst) begin
            arready      <= 1'b0;
            rvalid       <= 1'b0;
            rlast        <= 1'b0;
            burst_active <= 1'b0;
            beats_done   <= 0;
        end else begin
            if (arvalid && arready) begin
                arready      <= 1'b0;
                burst_active <= 1'b1;
                burst_addr   <= araddr;
                beats_done   <= 0;
            end else if (arvalid && !burst_active) begin
                rnd = lcg_next();
                arready <= |rnd[17:16];
            end
            if (burst_active) begin
                beats_next = beats_done + ((rvalid && rready) ? 1 : 0);
                beats_done <= beats_next;
                if (rvalid && !rready) begin
                    // beat held until taken
                    rvalid <= 1'b1;
                end else if (beats_next == words_per_line) begin
                    burst_active <= 1'b0;
                    rvalid       <= 1'b0;
                    rlast        <= 1'b0;
                end else begin
                    rnd = lcg_next();
                    if (|rnd[17:16]) begin
                        rvalid    <= 1'b1;
                        rdata_axi <= beat_word(burst_addr, beats_next);
                        rlast     <= (beats_next == words_per_line - 1);
                    end else begin
                        rvalid <= 1'b0;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // acceptance, ar requests and results

    always @(posedge clk) begin
        int idx;
        if (rst) begin
            if (index_ok && !seen_index_ok) begin
                seen_index_ok = 1'b1;
                if (cycle_cnt < num_sets) begin
                    $display("index_ok rose after only %0d cycles of sweep", cycle_cnt);
                    other_count++;
                end
            end
            if (rvalid && !rready) begin
                $display("rready low while a read beat is waiting");
                other_count++;
            end
            if (arvalid && arready) begin
                if (pending_q.size() == 0) begin
                    $display("AR request seen with no fetch outstanding");
                    other_count++;
                end else begin
                    idx = pending_q[0];
                    ar_seen[idx]++;
                    check_value($sformatf("fetch %0d araddr", idx),
                                {test_addr[idx][31:4], 4'b0000}, araddr);
                end
            end
            if (data_ok) begin
                if (pending_q.size() == 0) begin
                    $display("data_ok seen with no fetch outstanding");
                    other_count++;
                end else begin
                    idx = pending_q.pop_front();
                    check_value($sformatf("fetch %0d data", idx), test_half[idx], rdata);
                    check_value($sformatf("fetch %0d ar count", idx),
                                test_flags[idx][0], ar_seen[idx]);
                    if (!test_flags[idx][0]) begin
                        check_value($sformatf("fetch %0d hit latency", idx), 2,
                                    cycle_cnt - accept_cycle[idx]);
                    end
                    results_done <= results_done + 1;
                end
            end
            if (req && index_ok) begin
                pending_q.push_back(accepted);
                accept_cycle[accepted] = cycle_cnt;
                ar_seen[accepted]      = 0;
                accepted++;
            end
            cycle_cnt++;
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus from the input file

    initial begin
        int i;
        for (i = 0; i < 3 * max_tests; i++) begin
            vec_mem[i] = ~128'(i);
        end
        $readmemh("icache_input.txt", vec_mem);
        while (n_tests < max_tests && vec_mem[3*n_tests][127:32] == '0) begin
            test_addr[n_tests]  = vec_mem[3*n_tests][31:0];
            test_flags[n_tests] = vec_mem[3*n_tests+1][1:0];
            test_half[n_tests]  = vec_mem[3*n_tests+2];
            n_tests++;
        end
        if (n_tests == 0) begin
            $display("no fetches read from icache_input.txt");
            other_count++;
        end
        file_loaded = 1'b1;

        repeat (2) @(posedge clk);
        rst <= 1'b1;

        for (i = 0; i < n_tests; i++) begin
            // flag bit 1 issues without waiting for earlier results
            if (!test_flags[i][1]) begin
                req <= 1'b0;
                while (results_done != i) @(posedge clk);
            end
            req  <= 1'b1;
            addr <= test_addr[i];
            @(posedge clk);
            while (!index_ok) @(posedge clk);
        end
        req <= 1'b0;
        while (results_done != n_tests) @(posedge clk);
        repeat (4) @(posedge clk);

        if (dut_i.assertions_i.failures != 0) begin
            $display("concurrent assertions failed %0d times", dut_i.assertions_i.failures);
            other_count += dut_i.assertions_i.failures;
        end
        $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog scaled by the number of fetches
    initial begin
        int limit;
        wait (file_loaded);
        limit = (num_sets + 20 + n_tests * cycles_per_test) * clk_period;
        #(limit);
        $display("timeout: run did not complete within %0d ns", limit);
        $display("errors: %0d mismatches, %0d other", mismatch_count, other_count + 1);
        $display("Test failed");
        $finish;
    end

endmodule

/* icache_input.txt */
// columns: fetch address, flags, expected 128-bit half (word 0 in the low bits)
// flags: bit 0 expects a miss with one AR burst, bit 1 issues right after the previous fetch
00001000 1 10000403100004021000040110000400
00001000 0 10000403100004021000040110000400
00001010 0 10000407100004061000040510000404
00001000 0 10000403100004021000040110000400
00001010 2 10000407100004061000040510000404
00001000 2 10000403100004021000040110000400
00023470 1 10008d1f10008d1e10008d1d10008d1c
00023460 0 10008d1b10008d1a10008d1910008d18
00023470 2 10008d1f10008d1e10008d1d10008d1c
000100a0 1 1000402b1000402a1000402910004028
000110a0 1 1000442b1000442a1000442910004428
000120a0 1 1000482b1000482a1000482910004828
000130a0 1 10004c2b10004c2a10004c2910004c28
000140a0 1 1000502b1000502a1000502910005028
000110a0 0 1000442b1000442a1000442910004428
000100a0 1 1000402b1000402a1000402910004028
000130a0 0 10004c2b10004c2a10004c2910004c28
000140a0 2 1000502b1000502a1000502910005028
000100a0 2 1000402b1000402a1000402910004028
00001010 0 10000407100004061000040510000404

/* flist.f */
icache_pkg.sv
icache_way.sv
icache_ctrl.sv
icache_hit_select.sv
icache_plru.sv
icache_refill.sv
icache_top.sv
icache_assertions.sv
tb_icache.sv
